// File: common/sram_port_pkg.sv
package sram_port_pkg;

    // bus geometry
    localparam int word_w     = 32;
    localparam int path_words = 4;   // 128-bit code path
    localparam int tree_words = 2;   // 64-bit tree element

    // memory map of the external SRAM window
    localparam logic [31:0] bus_base    = 32'h3300_0000;   // also the tree region
    localparam logic [31:0] hist_offset = 32'h0000_1024;   // histogram and codebook

    localparam logic [3:0] sel_all = 4'b1111;

    // encoder phase as driven by the controller, unlisted codes mean idle
    typedef enum logic [2:0] {
        PH_HIST = 3'd1,
        PH_CB   = 3'd4,
        PH_TRN  = 3'd5
    } phase_e;

    // job kinds handed from decode to execute and result
    typedef enum logic [2:0] {
        JOB_CLEAR   = 3'd0,
        JOB_HIST_RD = 3'd1,
        JOB_HIST_WR = 3'd2,
        JOB_CB_WR   = 3'd3,
        JOB_TREE_RD = 3'd4,
        JOB_TRN_RD  = 3'd5
    } job_e;

endpackage

// File: logic/hist_clear.sv
`timescale 1ns/100ps

module hist_clear #(
    parameter int hist_depth = 2048
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                job_done_i,
    input  sram_port_pkg::job_e job_kind_i,
    output logic                clear_req_o,
    output logic [11:0]         clear_index_o,
    output logic                init_o
);
    import sram_port_pkg::*;

    logic [11:0] word_cnt_q;
    logic        init_q;
    logic        clear_done;

    // one clear job finished on the bus
    assign clear_done = job_done_i && (job_kind_i == JOB_CLEAR) && init_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            word_cnt_q <= '0;
            init_q     <= 1'b1;
        end else if (clear_done) begin
            if (word_cnt_q == 12'(hist_depth - 1)) begin
                init_q <= 1'b0;   // region fully zeroed
            end else begin
                word_cnt_q <= word_cnt_q + 12'd1;
            end
        end
    end

    // request stays up until the last word is written
    assign clear_req_o   = init_q;
    assign clear_index_o = word_cnt_q;
    assign init_o        = init_q;

endmodule

// File: sram_port/sram_decode.sv
`timescale 1ns/100ps

module sram_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  sram_port_pkg::phase_e         phase_i,
    input  logic                          clear_req_i,
    input  logic [11:0]                   clear_index_i,
    input  logic                          hist_req_i,
    input  logic                          hist_wr_i,
    input  logic [7:0]                    hist_addr_i,
    input  logic [sram_port_pkg::word_w-1:0] hist_count_i,
    input  logic                          cb_req_i,
    input  logic                          cb_wr_i,
    input  logic [7:0]                    char_index_i,
    input  logic [7:0]                    curr_index_i,
    input  logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] path_wr_i,
    input  logic                          trn_req_i,
    input  logic [7:0]                    trn_index_i,
    input  logic                          job_done_i,
    output logic                          job_start_o,
    output sram_port_pkg::job_e           job_kind_o,
    output logic [31:0]                   job_addr_o,
    output logic [2:0]                    job_beats_o,
    output logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] job_wdata_o
);
    import sram_port_pkg::*;

    localparam logic [31:0] hist_base = bus_base + hist_offset;
    localparam int          data_w    = path_words * word_w;

    logic              busy_q;
    logic              take;
    job_e              kind_n;
    logic [31:0]       addr_n;
    logic [2:0]        beats_n;
    logic [data_w-1:0] wdata_n;

    // pick at most one job, clear first
    always_comb begin
        take    = 1'b0;
        kind_n  = job_kind_o;
        addr_n  = job_addr_o;
        beats_n = job_beats_o;
        wdata_n = job_wdata_o;
        if (!busy_q) begin
            if (phase_i == PH_HIST && clear_req_i) begin
                take    = 1'b1;
                kind_n  = JOB_CLEAR;
                addr_n  = hist_base + {18'd0, clear_index_i, 2'b00};
                beats_n = 3'd1;
                wdata_n = '0;
            end else if (phase_i == PH_HIST && hist_req_i) begin
                take    = 1'b1;
                kind_n  = hist_wr_i ? JOB_HIST_WR : JOB_HIST_RD;
                addr_n  = hist_base + {22'd0, hist_addr_i, 2'b00};
                beats_n = 3'd1;
                wdata_n = {hist_count_i, {(data_w - word_w){1'b0}}};   // word 0 on top
            end else if (phase_i == PH_CB && cb_req_i) begin
                take = 1'b1;
                if (cb_wr_i) begin
                    kind_n  = JOB_CB_WR;
                    addr_n  = hist_base + {21'd0, char_index_i[6:0], 4'b0000};
                    beats_n = 3'(path_words);
                    wdata_n = path_wr_i;
                end else begin
                    kind_n  = JOB_TREE_RD;
                    addr_n  = bus_base + {22'd0, curr_index_i, 2'b00};
                    beats_n = 3'(tree_words);
                    wdata_n = '0;
                end
            end else if (phase_i == PH_TRN && trn_req_i) begin
                take    = 1'b1;
                kind_n  = JOB_TRN_RD;
                addr_n  = hist_base + {21'd0, trn_index_i[6:0], 4'b0000};
                beats_n = 3'(path_words);
                wdata_n = '0;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy_q      <= 1'b0;
            job_start_o <= 1'b0;
            job_kind_o  <= JOB_CLEAR;
            job_addr_o  <= bus_base;
            job_beats_o <= 3'd1;
            job_wdata_o <= '0;
        end else begin
            job_start_o <= take;
            if (take) begin
                busy_q      <= 1'b1;
                job_kind_o  <= kind_n;
                job_addr_o  <= addr_n;
                job_beats_o <= beats_n;
                job_wdata_o <= wdata_n;
            end else if (job_done_i) begin
                busy_q <= 1'b0;   // job stays latched until the next one
            end
        end
    end

endmodule

// File: sram_port/sram_execute.sv
`timescale 1ns/100ps

module sram_execute (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          job_start_i,
    input  sram_port_pkg::job_e           job_kind_i,
    input  logic [31:0]                   job_addr_i,
    input  logic [2:0]                    job_beats_i,
    input  logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] job_wdata_i,
    input  logic                          busy_i,
    output logic                          wr_en_o,
    output logic                          r_en_o,
    output logic [3:0]                    sel_o,
    output logic [31:0]                   addr_o,
    output logic [sram_port_pkg::word_w-1:0] wdata_o,
    output logic                          beat_done_o,
    output logic [1:0]                    beat_index_o,
    output logic                          job_done_o
);
    import sram_port_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_e;

    state_e     state_q;
    logic [1:0] beat_q;
    logic       busy_q;
    logic       is_write;
    logic       beat_end;
    logic       last_beat;
    logic [1:0] word_sel;

    assign is_write = (job_kind_i == JOB_CLEAR)
                   || (job_kind_i == JOB_HIST_WR)
                   || (job_kind_i == JOB_CB_WR);

    // falling edge of busy closes the open beat
    assign beat_end  = busy_q && !busy_i;
    assign last_beat = ({1'b0, beat_q} == job_beats_i - 3'd1);
    assign word_sel  = 2'(path_words - 1) - beat_q;   // msw first

    assign wr_en_o = (state_q == S_ISSUE) && is_write;
    assign r_en_o  = (state_q == S_ISSUE) && !is_write;
    assign sel_o   = sel_all;
    assign addr_o  = job_addr_i + {28'd0, beat_q, 2'b00};
    assign wdata_o = job_wdata_i[word_sel*word_w +: word_w];

    assign beat_done_o  = (state_q == S_WAIT) && beat_end;
    assign beat_index_o = beat_q;
    assign job_done_o   = beat_done_o && last_beat;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
            busy_q  <= 1'b0;
        end else begin
            busy_q <= busy_i;
            case (state_q)
                S_IDLE: begin
                    if (job_start_i) begin
                        beat_q  <= '0;
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    state_q <= S_WAIT;   // device answers with busy next cycle
                end
                S_WAIT: begin
                    if (beat_end) begin
                        if (last_beat) begin
                            state_q <= S_IDLE;
                        end else begin
                            beat_q  <= beat_q + 2'd1;
                            state_q <= S_ISSUE;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: sram_port/sram_result.sv
`timescale 1ns/100ps

module sram_result (
    input  logic                          clk,
    input  logic                          rst,
    input  sram_port_pkg::job_e           job_kind_i,
    input  logic                          beat_done_i,
    input  logic [1:0]                    beat_index_i,
    input  logic                          job_done_i,
    input  logic [sram_port_pkg::word_w-1:0] rdata_i,
    output logic [sram_port_pkg::word_w-1:0] hist_count_o,
    output logic [sram_port_pkg::tree_words*sram_port_pkg::word_w-1:0] tree_elem_o,
    output logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] path_o,
    output logic                          hist_done_o,
    output logic                          cb_done_o,
    output logic                          trn_done_o
);
    import sram_port_pkg::*;

    logic [1:0] path_sel;
    logic       tree_sel;

    // beat 0 lands in the top word
    assign path_sel = 2'(path_words - 1) - beat_index_i;
    assign tree_sel = 1'(tree_words - 1) - beat_index_i[0];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hist_count_o <= '0;
            tree_elem_o  <= '0;
            path_o       <= '0;
        end else if (beat_done_i) begin
            case (job_kind_i)
                JOB_HIST_RD: hist_count_o <= rdata_i;
                JOB_TREE_RD: tree_elem_o[tree_sel*word_w +: word_w] <= rdata_i;
                JOB_TRN_RD:  path_o[path_sel*word_w +: word_w] <= rdata_i;
                default: begin
                end
            endcase
        end
    end

    // done pulses trail job_done by one cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hist_done_o <= 1'b0;
            cb_done_o   <= 1'b0;
            trn_done_o  <= 1'b0;
        end else begin
            hist_done_o <= job_done_i
                        && (job_kind_i == JOB_HIST_RD || job_kind_i == JOB_HIST_WR);
            cb_done_o   <= job_done_i
                        && (job_kind_i == JOB_CB_WR || job_kind_i == JOB_TREE_RD);
            trn_done_o  <= job_done_i && (job_kind_i == JOB_TRN_RD);
        end
    end

endmodule

// File: sram_port/sram_port.sv
`timescale 1ns/100ps

module sram_port #(
    parameter int hist_depth = 2048
) (
    input  logic                          clk,
    input  logic                          rst,
    input  sram_port_pkg::phase_e         phase_i,
    input  logic                          hist_req_i,
    input  logic                          hist_wr_i,
    input  logic [7:0]                    hist_addr_i,
    input  logic [sram_port_pkg::word_w-1:0] hist_count_i,
    input  logic                          cb_req_i,
    input  logic                          cb_wr_i,
    input  logic [7:0]                    char_index_i,
    input  logic [7:0]                    curr_index_i,
    input  logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] path_wr_i,
    input  logic                          trn_req_i,
    input  logic [7:0]                    trn_index_i,
    input  logic                          busy_i,
    input  logic [sram_port_pkg::word_w-1:0] rdata_i,
    output logic                          wr_en_o,
    output logic                          r_en_o,
    output logic [3:0]                    sel_o,
    output logic [31:0]                   addr_o,
    output logic [sram_port_pkg::word_w-1:0] wdata_o,
    output logic                          init_o,
    output logic [sram_port_pkg::word_w-1:0] hist_count_o,
    output logic                          hist_done_o,
    output logic [sram_port_pkg::tree_words*sram_port_pkg::word_w-1:0] tree_elem_o,
    output logic                          cb_done_o,
    output logic [sram_port_pkg::path_words*sram_port_pkg::word_w-1:0] path_o,
    output logic                          trn_done_o
);
    import sram_port_pkg::*;

    logic                           clear_req;
    logic [11:0]                    clear_index;
    logic                           job_start;
    job_e                           job_kind;
    logic [31:0]                    job_addr;
    logic [2:0]                     job_beats;
    logic [path_words*word_w-1:0]   job_wdata;
    logic                           beat_done;
    logic [1:0]                     beat_index;
    logic                           job_done;

    hist_clear #(
        .hist_depth(hist_depth)
    ) hist_clear_inst (
        .clk          (clk),
        .rst          (rst),
        .job_done_i   (job_done),
        .job_kind_i   (job_kind),
        .clear_req_o  (clear_req),
        .clear_index_o(clear_index),
        .init_o       (init_o)
    );

    sram_decode sram_decode_inst (
        .clk          (clk),
        .rst          (rst),
        .phase_i      (phase_i),
        .clear_req_i  (clear_req),
        .clear_index_i(clear_index),
        .hist_req_i   (hist_req_i),
        .hist_wr_i    (hist_wr_i),
        .hist_addr_i  (hist_addr_i),
        .hist_count_i (hist_count_i),
        .cb_req_i     (cb_req_i),
        .cb_wr_i      (cb_wr_i),
        .char_index_i (char_index_i),
        .curr_index_i (curr_index_i),
        .path_wr_i    (path_wr_i),
        .trn_req_i    (trn_req_i),
        .trn_index_i  (trn_index_i),
        .job_done_i   (job_done),
        .job_start_o  (job_start),
        .job_kind_o   (job_kind),
        .job_addr_o   (job_addr),
        .job_beats_o  (job_beats),
        .job_wdata_o  (job_wdata)
    );

    sram_execute sram_execute_inst (
        .clk         (clk),
        .rst         (rst),
        .job_start_i (job_start),
        .job_kind_i  (job_kind),
        .job_addr_i  (job_addr),
        .job_beats_i (job_beats),
        .job_wdata_i (job_wdata),
        .busy_i      (busy_i),
        .wr_en_o     (wr_en_o),
        .r_en_o      (r_en_o),
        .sel_o       (sel_o),
        .addr_o      (addr_o),
        .wdata_o     (wdata_o),
        .beat_done_o (beat_done),
        .beat_index_o(beat_index),
        .job_done_o  (job_done)
    );

    sram_result sram_result_inst (
        .clk         (clk),
        .rst         (rst),
        .job_kind_i  (job_kind),
        .beat_done_i (beat_done),
        .beat_index_i(beat_index),
        .job_done_i  (job_done),
        .rdata_i     (rdata_i),
        .hist_count_o(hist_count_o),
        .tree_elem_o (tree_elem_o),
        .path_o      (path_o),
        .hist_done_o (hist_done_o),
        .cb_done_o   (cb_done_o),
        .trn_done_o  (trn_done_o)
    );

endmodule

// File: test/sram_bus_model.sv
`timescale 1ns/100ps

module sram_bus_model #(
    parameter int depth = 2048
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en_i,
    input  logic        r_en_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [2:0]  busy_len_i,
    output logic        busy_o,
    output logic [31:0] rdata_o
);
    localparam int aw = $clog2(depth);

    logic [31:0]   mem [depth];
    logic [2:0]    left_q;
    logic          rd_q;
    logic [aw-1:0] rd_idx_q;
    logic [aw-1:0] idx;

    assign idx = addr_i[aw+1:2];   // window base is aligned

    // nonzero fill, different for every word
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = {16'h5a5a ^ 16'(i), 16'(i) + 16'd1};
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_o   <= 1'b0;
            left_q   <= '0;
            rd_q     <= 1'b0;
            rd_idx_q <= '0;
            rdata_o  <= '0;
        end else if (wr_en_i || r_en_i) begin
            busy_o   <= 1'b1;
            left_q   <= busy_len_i;
            rd_q     <= r_en_i;
            rd_idx_q <= idx;
            for (int b = 0; b < 4; b++) begin
                if (wr_en_i && sel_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end else if (busy_o) begin
            left_q <= left_q - 3'd1;
            if (left_q == 3'd1) begin
                busy_o <= 1'b0;
                if (rd_q) begin
                    rdata_o <= mem[rd_idx_q];   // valid in the cycle busy falls
                end
            end
        end
    end

endmodule

// File: test/tb_sram_port.sv
`timescale 1ns/100ps

module tb_sram_port;
    import sram_port_pkg::*;

    localparam int hist_depth  = 16;
    localparam int hist_rounds = 3;
    localparam int cb_rounds   = 2;
    localparam int tree_rounds = 2;
    // clear + 5 quiet
    localparam int n_jobs      = 6 + 2 * hist_rounds + 2 * cb_rounds + tree_rounds;
    localparam int hist_word   = int'(hist_offset >> 2);

    logic         clk;
    logic         rst = 1'b1;
    phase_e       phase_i = phase_e'(3'd0);
    logic         hist_req_i = 1'b0, hist_wr_i = 1'b0, cb_req_i = 1'b0, cb_wr_i = 1'b0;
    logic         trn_req_i = 1'b0;
    logic [7:0]   hist_addr_i = '0, char_index_i = '0, curr_index_i = '0, trn_index_i = '0;
    logic [31:0]  hist_count_i = '0;
    logic [127:0] path_wr_i = '0;
    logic         busy_i, wr_en_o, r_en_o, init_o, hist_done_o, cb_done_o, trn_done_o;
    logic [31:0]  rdata_i, addr_o, wdata_o, hist_count_o;
    logic [3:0]   sel_o;
    logic [63:0]  tree_elem_o;
    logic [127:0] path_o;
    logic [2:0]   busy_len = 3'd1;
    logic [31:0]  lfsr_q = 32'had58;
    logic [31:0]  wr_log[$];

    sram_port #(.hist_depth(hist_depth)) sram_port_inst (.*);

    sram_bus_model bus_model_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en_o),
        .r_en_i    (r_en_o),
        .sel_i     (sel_o),
        .addr_i    (addr_o),
        .wdata_i   (wdata_o),
        .busy_len_i(busy_len),
        .busy_o    (busy_i),
        .rdata_o   (rdata_i)
    );

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b      = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], b};
            r      = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [127:0] exp, act);
        assert (exp === act)
            else report_failure($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    endtask

    // kind 0 histogram, 1 codebook, 2 translation
    // ports the request does not use carry the complement
    task automatic issue_request(input int kind, input logic wr, input logic [7:0] idx,
                                 input logic [127:0] data);
        @(posedge clk);
        hist_wr_i    <= (kind == 0) ? wr : !wr;
        cb_wr_i      <= (kind == 1) ? wr : !wr;
        hist_addr_i  <= (kind == 0) ? idx : ~idx;
        char_index_i <= (kind == 1 && wr) ? idx : ~idx;
        curr_index_i <= (kind == 1 && !wr) ? idx : ~idx;
        trn_index_i  <= (kind == 2) ? idx : ~idx;
        hist_count_i <= (kind == 0) ? data[31:0] : ~data[31:0];
        path_wr_i    <= (kind == 1) ? data : ~data;
        {hist_req_i, cb_req_i, trn_req_i} <= 3'b100 >> kind;
        @(posedge clk);
        {hist_req_i, cb_req_i, trn_req_i} <= 3'b000;
    endtask

    task automatic wait_done(input int kind);
        do begin
            @(negedge clk);
        end while (!(kind == 0 ? hist_done_o : (kind == 1 ? cb_done_o : trn_done_o)));
    endtask

    task automatic expect_quiet(input int kind);
        issue_request(kind, 1'b1, 8'h11, '0);
        repeat (20) begin
            @(negedge clk);
            assert (!(wr_en_o || r_en_o || hist_done_o || cb_done_o || trn_done_o))
                else report_failure("a request under the wrong phase reached the bus");
        end
    endtask

    task automatic set_phase(input phase_e p);
        @(posedge clk);
        phase_i <= p;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        busy_len <= 3'd1 + 3'(rand_bits(2));   // 1 to 4 busy cycles
    end

    always @(posedge clk) begin
        if (!rst && wr_en_o) begin
            wr_log.push_back(addr_o);
        end
    end

    initial begin
        repeat (n_jobs * 400) @(posedge clk);
        report_failure("timeout: the DUT did not finish the test jobs in time");
    end

    assert property (@(posedge clk) disable iff (rst) !(wr_en_o && r_en_o))
        else report_failure("write and read strobes were high in the same cycle");
    assert property (@(posedge clk) disable iff (rst) sel_o == sel_all)
        else report_failure($sformatf("ERROR sel_o expected %h actual %h", sel_all, sel_o));
    assert property (@(posedge clk) disable iff (rst)
                     (wr_en_o || r_en_o) |-> !(busy_i || $past(busy_i)))
        else report_failure("a strobe was issued while a bus beat was still open");

    initial begin
        logic [7:0]   idx;
        logic [31:0]  cnt;
        logic [31:0]  base;
        logic [127:0] path;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_equal("wr_en_o", 0, wr_en_o);
        expect_equal("r_en_o", 0, r_en_o);
        expect_equal("init_o", 1, init_o);
        expect_equal("addr_o", bus_base, addr_o);
        expect_equal("path_o", 0, path_o);
        expect_quiet(0);   // idle phase holds off the clear too
        set_phase(PH_HIST);
        while (init_o) @(negedge clk);
        expect_equal("clear writes", hist_depth, wr_log.size());
        for (int n = 0; n < hist_depth; n++) begin
            expect_equal("clear addr_o", bus_base + hist_offset + 4 * n, wr_log[n]);
            expect_equal("cleared word", 0, bus_model_inst.mem[hist_word + n]);
        end
        repeat (hist_rounds) begin
            @(negedge clk);
            idx = 8'(rand_bits(8));
            cnt = rand_bits(32);
            wr_log.delete();
            issue_request(0, 1'b1, idx, 128'(cnt));
            wait_done(0);
            expect_equal("hist writes", 1, wr_log.size());
            expect_equal("hist addr_o", bus_base + hist_offset + 4 * idx, wr_log[0]);
            expect_equal("hist word", cnt, bus_model_inst.mem[hist_word + idx]);
            issue_request(0, 1'b0, idx, '0);
            wait_done(0);
            expect_equal("hist_count_o", cnt, hist_count_o);
        end
        repeat (cb_rounds) begin
            set_phase(PH_CB);
            @(negedge clk);
            idx = 8'(rand_bits(8));
            for (int k = 0; k < 4; k++) begin
                path = {path[95:0], rand_bits(32)};
            end
            base = bus_base + hist_offset + 16 * idx[6:0];
            wr_log.delete();
            issue_request(1, 1'b1, idx, path);
            wait_done(1);
            expect_equal("path writes", 4, wr_log.size());
            for (int k = 0; k < 4; k++) begin
                expect_equal("path addr_o", base + 4 * k, wr_log[k]);
                expect_equal("path word", path[127 - 32 * k -: 32],
                             bus_model_inst.mem[(base - bus_base) / 4 + k]);
            end
            set_phase(PH_TRN);
            issue_request(2, 1'b0, idx, '0);
            wait_done(2);
            expect_equal("path_o", path, path_o);
        end
        set_phase(PH_CB);
        repeat (tree_rounds) begin
            @(negedge clk);
            idx = 8'(rand_bits(8));
            issue_request(1, 1'b0, idx, '0);
            wait_done(1);
            expect_equal("tree_elem_o",
                         {bus_model_inst.mem[idx], bus_model_inst.mem[idx + 1]}, tree_elem_o);
        end
        expect_quiet(0);
        expect_quiet(2);
        set_phase(PH_HIST);
        expect_quiet(1);
        set_phase(PH_TRN);
        expect_quiet(0);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sram_port.f
common/sram_port_pkg.sv
logic/hist_clear.sv
sram_port/sram_decode.sv
sram_port/sram_execute.sv
sram_port/sram_result.sv
sram_port/sram_port.sv
test/sram_bus_model.sv
test/tb_sram_port.sv
